// File: verilog/huff_pkg.sv
package huff_pkg;

  localparam int sym_n  = 16;                  // Leaf symbols
  localparam int slot_n = 31;                  // Live slots, leaves then sum nodes
  localparam int node_n = 15;                  // Stored sum nodes
  localparam int freq_w = 24;                  // Frequency width, sums wrap
  localparam int id_w   = 9;                   // Node id, bit 8 marks a sum node
  localparam int sym_w  = 4;
  localparam int slot_w = 5;
  localparam int nidx_w = 4;                   // Node index width
  localparam int cnt_w  = 4;                   // Node count width
  localparam int adr_w  = 7;                   // Word address
  localparam int dat_w  = 32;

  localparam logic [id_w-1:0] null_id = 9'b110000000;  // Second child of a closing node

  // Bus word map
  localparam logic [adr_w-1:0] freq_base = 7'h00;
  localparam logic [adr_w-1:0] ctrl_adr  = 7'h10;
  localparam logic [adr_w-1:0] stat_adr  = 7'h11;
  localparam logic [adr_w-1:0] node_base = 7'h20;  // Ids then frequency, two words per node

  typedef enum logic [2:0] {sel_freq, sel_ctrl, sel_stat, sel_node_ids, sel_node_freq,
                            sel_none} wb_sel_t;
  typedef enum logic [2:0] {b_idle, b_count, b_scan, b_wait, b_merge, b_close,
                            b_fin} build_state_t;
  typedef enum logic [1:0] {s_idle, s_run, s_done} scan_state_t;

  // Slot 0..15 is a leaf, slot 16..30 is sum node 0..14
  function automatic logic [id_w-1:0] slot_to_id(input logic [slot_w-1:0] slot);
    return {slot[slot_w-1], {(id_w-1-nidx_w){1'b0}}, slot[nidx_w-1:0]};
  endfunction

  function automatic logic [slot_w-1:0] id_to_slot(input logic [id_w-1:0] id);
    return {id[id_w-1], id[nidx_w-1:0]};     // Inverse of slot_to_id
  endfunction

endpackage

// File: verilog/huff_wb_regs.sv
module huff_wb_regs
  import huff_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [adr_w-1:0] adr,
  input  logic [dat_w-1:0] wdata,
  input  logic             busy,
  input  logic             done,
  input  logic [cnt_w-1:0] node_count,
  input  logic [id_w-1:0]  node_left,
  input  logic [id_w-1:0]  node_right,
  input  logic [freq_w-1:0] node_freq,
  output logic [dat_w-1:0] rdata,
  output logic             ack,
  output logic             freq_we,
  output logic [sym_w-1:0] freq_sym,
  output logic [freq_w-1:0] freq_val,
  output logic             start,
  output logic [nidx_w-1:0] node_radr
);

  wb_sel_t          sel;
  logic             req;                       // Master request this cycle
  logic             take;                      // First cycle of a request, acts once
  logic             acked;                     // Request already served, wait for stb low
  logic [dat_w-1:0] rd_mux;

  assign req  = cyc & stb;
  assign take = req & ~acked;

  // Address decode
  always_comb begin
    if (adr < freq_base + adr_w'(sym_n)) begin
      sel = sel_freq;
    end else if (adr == ctrl_adr) begin
      sel = sel_ctrl;
    end else if (adr == stat_adr) begin
      sel = sel_stat;
    end else if (adr >= node_base && adr < node_base + adr_w'(2 * node_n)) begin
      sel = adr[0] ? sel_node_freq : sel_node_ids;  // Odd word holds the sum
    end else begin
      sel = sel_none;
    end
  end

  assign node_radr = nidx_w'((adr - node_base) >> 1);   // Two words per node
  assign freq_sym  = adr[sym_w-1:0];
  assign freq_val  = wdata[freq_w-1:0];
  assign freq_we   = take & we & (sel == sel_freq) & ~busy;   // Dropped during a build
  assign start     = take & we & (sel == sel_ctrl) & wdata[0] & ~busy;

  // Read data select
  always_comb begin
    case (sel)
      sel_stat:      rd_mux = dat_w'({node_count, 6'b0, done, busy});
      sel_node_ids:  rd_mux = {7'b0, node_left, 7'b0, node_right};  // Left in 24:16
      sel_node_freq: rd_mux = dat_w'(node_freq);
      default:       rd_mux = '0;               // Frequencies and control are write only
    endcase
  end

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      ack   <= 1'b0;
      acked <= 1'b0;
    end else begin
      ack   <= take;                            // One cycle after the request
      acked <= req & (acked | take);            // Cleared once stb falls
    end
  end

  // Read word lands together with ack
  always_ff @(posedge clk) begin
    if (take && !we) begin
      rdata <= rd_mux;
    end
  end

endmodule

// File: verilog/huff_node_store.sv
module huff_node_store
  import huff_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              freq_we,
  input  logic [sym_w-1:0]  freq_sym,
  input  logic [freq_w-1:0] freq_val,
  input  logic              clear,
  input  logic [slot_w-1:0] slot_radr,
  input  logic              retire,
  input  logic [slot_w-1:0] retire_a,
  input  logic [slot_w-1:0] retire_b,
  input  logic              node_we,
  input  logic [nidx_w-1:0] node_wadr,
  input  logic [id_w-1:0]   node_left,
  input  logic [id_w-1:0]   node_right,
  input  logic [freq_w-1:0] node_sum,
  input  logic [nidx_w-1:0] node_radr,
  output logic              slot_live,
  output logic [freq_w-1:0] slot_freq,
  output logic [id_w-1:0]   rd_left,
  output logic [id_w-1:0]   rd_right,
  output logic [freq_w-1:0] rd_freq
);

  logic [freq_w-1:0] freq_mem  [slot_n];      // Leaf frequencies, then sum slots
  logic [id_w-1:0]   left_mem  [node_n];
  logic [id_w-1:0]   right_mem [node_n];
  logic [freq_w-1:0] sum_mem   [node_n];
  logic [slot_n-1:0] live;
  logic [slot_w-1:0] new_slot;

  assign new_slot = {1'b1, node_wadr};         // Slot 16 plus node index

  always_ff @(posedge clk) begin
    if (freq_we) begin
      freq_mem[{1'b0, freq_sym}] <= freq_val;  // Host load, leaves only
    end
    if (node_we) begin
      freq_mem[new_slot]   <= node_sum;
      left_mem[node_wadr]  <= node_left;
      right_mem[node_wadr] <= node_right;
      sum_mem[node_wadr]   <= node_sum;
    end
  end

  // Live bits
  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      live <= '0;
    end else if (clear) begin
      live <= '0;                              // Sum slots die here
      for (int i = 0; i < sym_n; i++) begin
        live[i] <= (freq_mem[i] != '0);        // Zero-frequency leaves never take part
      end
    end else begin
      if (retire) begin
        live[retire_a] <= 1'b0;
        live[retire_b] <= 1'b0;
      end
      if (node_we) live[new_slot] <= 1'b1;     // New sum joins the pool
    end
  end

  assign slot_live = live[slot_radr];
  assign slot_freq = freq_mem[slot_radr];
  assign rd_left   = left_mem[node_radr];
  assign rd_right  = right_mem[node_radr];
  assign rd_freq   = sum_mem[node_radr];

endmodule

// File: verilog/huff_min_scan.sv
module huff_min_scan
  import huff_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              scan_go,
  input  logic              slot_live,
  input  logic [freq_w-1:0] slot_freq,
  output logic [slot_w-1:0] slot_radr,
  output logic              scan_done,
  output logic [id_w-1:0]   least1,
  output logic [id_w-1:0]   least2,
  output logic [1:0]        found,
  output logic [freq_w-1:0] slot_freq_a,   // Frequency of least1
  output logic [freq_w-1:0] slot_freq_b    // Frequency of least2
);

  scan_state_t       state;
  logic [slot_w-1:0] idx;
  logic              last;
  logic [id_w-1:0]   cand;
  logic              beat1;                  // Slot becomes the new best
  logic              beat2;                  // Slot becomes the new second

  assign slot_radr = idx;
  assign last      = (idx == slot_w'(slot_n - 1));
  assign cand      = slot_to_id(idx);
  assign scan_done = (state == s_done);

  // Strict compare keeps the lower slot on a tie
  assign beat1 = slot_live && (found == 2'd0 || slot_freq < slot_freq_a);
  assign beat2 = slot_live && (found != 2'd2 || slot_freq < slot_freq_b);

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      state <= s_idle;
      idx   <= '0;
      found <= 2'd0;
    end else begin
      case (state)
        s_idle: begin
          if (scan_go) begin
            state <= s_run;
            idx   <= '0;
            found <= 2'd0;
          end
        end
        s_run: begin
          if (slot_live && found != 2'd2) found <= found + 2'd1;  // Saturates at two
          if (last) begin
            state <= s_done;                 // 31 slots read, result next cycle
          end else begin
            idx <= idx + 1'b1;
          end
        end
        s_done:  state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  // Best and second-best candidates
  always_ff @(posedge clk) begin
    if (state == s_idle && scan_go) begin
      least1      <= null_id;                // Missing nodes read as null
      least2      <= null_id;
      slot_freq_a <= '0;
      slot_freq_b <= '0;
    end else if (state == s_run) begin
      if (beat1) begin
        least2      <= least1;               // Old best drops to second
        slot_freq_b <= slot_freq_a;
        least1      <= cand;
        slot_freq_a <= slot_freq;
      end else if (beat2) begin
        least2      <= cand;
        slot_freq_b <= slot_freq;
      end
    end
  end

endmodule

// File: verilog/huff_tree_build.sv
module huff_tree_build
  import huff_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              scan_done,
  input  logic [id_w-1:0]   least1,
  input  logic [id_w-1:0]   least2,
  input  logic [1:0]        found,
  input  logic [freq_w-1:0] slot_freq_a,
  input  logic [freq_w-1:0] slot_freq_b,
  output logic              clear,
  output logic              scan_go,
  output logic              node_we,
  output logic [nidx_w-1:0] node_wadr,
  output logic [id_w-1:0]   node_left,
  output logic [id_w-1:0]   node_right,
  output logic [freq_w-1:0] node_sum,
  output logic              retire,
  output logic [slot_w-1:0] retire_a,
  output logic [slot_w-1:0] retire_b,
  output logic              busy,
  output logic              done,
  output logic [cnt_w-1:0]  node_count
);

  build_state_t state;
  build_state_t state_nx;
  logic         closing;                     // Single-leaf closing write
  logic         merging;

  assign closing = (state == b_close);
  assign merging = (state == b_merge);

  // Next state
  always_comb begin
    state_nx = state;
    case (state)
      b_idle: begin
        if (start) state_nx = b_count;
      end
      b_count: state_nx = b_scan;            // Store rebuilds live bits, scan kicks off
      b_scan: begin
        if (scan_done) begin
          if (found == 2'd2) begin
            state_nx = b_merge;              // Two nodes left to join
          end else if (found == 2'd1 && node_count == '0) begin
            state_nx = b_close;              // Lone leaf, nothing merged yet
          end else begin
            state_nx = b_fin;                // Root reached or empty input
          end
        end
      end
      b_merge: state_nx = b_wait;
      b_wait:  state_nx = b_scan;            // Rescan with the new sum live
      b_close: state_nx = b_fin;
      b_fin:   state_nx = b_idle;
      default: state_nx = b_idle;
    endcase
  end

  // Store and scanner strobes
  assign clear   = (state == b_count);
  assign scan_go = (state == b_count) || (state == b_wait);
  assign node_we = merging || closing;
  assign retire  = node_we;                  // Children leave the pool as the parent lands
  assign busy    = (state != b_idle);

  // Node record, least1 is always the left child
  assign node_wadr  = node_count;
  assign node_left  = least1;
  assign node_right = closing ? null_id : least2;
  assign node_sum   = closing ? slot_freq_a : slot_freq_a + slot_freq_b;  // Wraps at freq_w

  assign retire_a = id_to_slot(least1);
  assign retire_b = closing ? id_to_slot(least1) : id_to_slot(least2);  // Same slot twice

  always_ff @(posedge clk, posedge rst_n) begin
    if (rst_n) begin
      state      <= b_idle;
      node_count <= '0;
      done       <= 1'b0;
    end else begin
      state <= state_nx;
      if (state == b_idle && start) begin
        node_count <= '0;                    // New build drops the old result
        done       <= 1'b0;
      end
      if (node_we) node_count <= node_count + 1'b1;
      if (state == b_fin) done <= 1'b1;      // Held until the next start
    end
  end

endmodule

// File: verilog/huff_top.sv
module huff_top
  import huff_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [adr_w-1:0] adr,
  input  logic [dat_w-1:0] wdata,
  output logic [dat_w-1:0] rdata,
  output logic             ack
);

  // Host side
  logic              freq_we;
  logic [sym_w-1:0]  freq_sym;
  logic [freq_w-1:0] freq_val;
  logic              start;
  logic              busy;
  logic              done;
  logic [cnt_w-1:0]  node_count;
  logic [nidx_w-1:0] node_radr;
  logic [id_w-1:0]   rd_left;
  logic [id_w-1:0]   rd_right;
  logic [freq_w-1:0] rd_freq;

  // Scan path
  logic              scan_go;
  logic              scan_done;
  logic [slot_w-1:0] slot_radr;
  logic              slot_live;
  logic [freq_w-1:0] slot_freq;
  logic [id_w-1:0]   least1;
  logic [id_w-1:0]   least2;
  logic [1:0]        found;
  logic [freq_w-1:0] slot_freq_a;
  logic [freq_w-1:0] slot_freq_b;

  // Build writes
  logic              clear;
  logic              node_we;
  logic [nidx_w-1:0] node_wadr;
  logic [id_w-1:0]   wr_left;
  logic [id_w-1:0]   wr_right;
  logic [freq_w-1:0] wr_sum;
  logic              retire;
  logic [slot_w-1:0] retire_a;
  logic [slot_w-1:0] retire_b;

  huff_wb_regs u_regs (
    .clk, .rst_n, .cyc, .stb, .we, .adr, .wdata, .busy, .done, .node_count,
    .node_left(rd_left), .node_right(rd_right), .node_freq(rd_freq),
    .rdata, .ack, .freq_we, .freq_sym, .freq_val, .start, .node_radr
  );

  huff_node_store u_store (
    .clk, .rst_n, .freq_we, .freq_sym, .freq_val, .clear, .slot_radr,
    .retire, .retire_a, .retire_b, .node_we, .node_wadr,
    .node_left(wr_left), .node_right(wr_right), .node_sum(wr_sum), .node_radr,
    .slot_live, .slot_freq, .rd_left, .rd_right, .rd_freq
  );

  huff_min_scan u_scan (
    .clk, .rst_n, .scan_go, .slot_live, .slot_freq, .slot_radr, .scan_done,
    .least1, .least2, .found, .slot_freq_a, .slot_freq_b
  );

  huff_tree_build u_build (
    .clk, .rst_n, .start, .scan_done, .least1, .least2, .found, .slot_freq_a,
    .slot_freq_b, .clear, .scan_go, .node_we, .node_wadr,
    .node_left(wr_left), .node_right(wr_right), .node_sum(wr_sum),
    .retire, .retire_a, .retire_b, .busy, .done, .node_count
  );

endmodule

// File: test/huff_tb_tasks.svh
`ifndef huff_tb_tasks_svh
`define huff_tb_tasks_svh

  // Report and stop at the first error
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // One Wishbone classic cycle, called and left one unit after a rising edge
  task automatic bus_cycle(input logic write, input logic [adr_w-1:0] a,
                           input logic [dat_w-1:0] d, output logic [dat_w-1:0] q);
    int waited;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = a;
    wdata  = d;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!ack && waited < 3);
    if (!ack) fail_run($sformatf("no Wishbone ack from address %h after %0d cycles", a, waited));
    if (waited != 1) begin
      fail_run($sformatf("Wishbone ack from address %h came %0d cycles late", a, waited - 1));
    end
    q   = rdata;                        // Read word is valid with ack
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(posedge clk);                     // Idle cycle lets the slave rearm
    #1;
    if (ack) fail_run($sformatf("Wishbone ack from address %h lasted two cycles", a));
  endtask

  task automatic bus_write(input logic [adr_w-1:0] a, input logic [dat_w-1:0] d);
    logic [dat_w-1:0] q;
    bus_cycle(1'b1, a, d, q);
  endtask

  task automatic bus_read(input logic [adr_w-1:0] a, output logic [dat_w-1:0] q);
    bus_cycle(1'b0, a, '0, q);
  endtask

  task automatic check_ids(input logic [id_w-1:0] got_l, input logic [id_w-1:0] got_r,
                           input logic [id_w-1:0] exp_l, input logic [id_w-1:0] exp_r,
                           input string what);
    if (got_l !== exp_l || got_r !== exp_r) begin
      fail_run($sformatf("ERR %0t: %s ids %h %h, expected %h %h",
                         $time, what, got_l, got_r, exp_l, exp_r));
    end
  endtask

  task automatic check_freq(input logic [freq_w-1:0] got, input logic [freq_w-1:0] exp,
                            input string what);
    if (got !== exp) fail_run($sformatf("ERR %0t: %s sum %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_stat(input logic [cnt_w-1:0] got_cnt, input logic got_done,
                            input logic got_busy, input logic [cnt_w-1:0] exp_cnt,
                            input logic exp_done, input logic exp_busy, input string what);
    if (got_cnt !== exp_cnt || got_done !== exp_done || got_busy !== exp_busy) begin
      fail_run($sformatf("ERR %0t: %s count %0d done %b busy %b, expected %0d %b %b", $time,
                         what, got_cnt, got_done, got_busy, exp_cnt, exp_done, exp_busy));
    end
  endtask

`endif

// File: test/huff_tb.sv
module huff_tb
  import huff_pkg::*;
();

  localparam int max_tests    = 8;
  localparam int build_cycles = node_n * 40 + 200;  // Per build, bus traffic included

  logic             clk;
  logic             rst_n;
  logic             cyc;
  logic             stb;
  logic             we;
  logic [adr_w-1:0] adr;
  logic [dat_w-1:0] wdata;
  logic [dat_w-1:0] rdata;
  logic             ack;

  int                n_tests;
  int                n_builds;                       // Tests plus reruns
  int                test_id   [max_tests];
  int                test_mode [max_tests];          // 1 adds writes during the build and a rerun
  int                exp_count [max_tests];
  logic [freq_w-1:0] leaf_freq [max_tests][sym_n];
  logic [id_w-1:0]   exp_left  [max_tests][node_n];
  logic [id_w-1:0]   exp_right [max_tests][node_n];
  logic [freq_w-1:0] exp_sum   [max_tests][node_n];
  int                cycles = 0;
  int                cycle_limit = build_cycles;
  integer            seed;

  huff_top u_huff_top (.clk, .rst_n, .cyc, .stb, .we, .adr, .wdata, .rdata, .ack);

  `include "huff_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the build never reported done", cycles);
      $display("test failed");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic read_hex(input int fd, output logic [31:0] val);
    int rc;
    rc = $fscanf(fd, "%h", val);
    if (rc != 1) fail_run("stimulus file ended early or holds a malformed value");
  endtask

  task automatic load_tests();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] val;
    fd = $fopen("test/huff_input.txt", "r");
    if (fd == 0) fail_run("cannot open test/huff_input.txt");
    line = "#";
    while (line.len() > 0 && line[0] == "#") begin   // Column notes
      rc = $fgets(line, fd);
      if (rc == 0) fail_run("stimulus file holds no test count");
    end
    rc = $sscanf(line, "%h", n_tests);
    if (rc != 1 || n_tests < 1 || n_tests > max_tests) fail_run("bad test count in stimulus file");
    n_builds = n_tests;
    for (int t = 0; t < n_tests; t++) begin
      read_hex(fd, val);
      test_id[t] = val;
      read_hex(fd, val);
      test_mode[t] = val;
      read_hex(fd, val);
      if (val > node_n) fail_run("expected node count in stimulus file is above 15");
      exp_count[t] = val;
      if (test_mode[t] == 1) n_builds++;
      for (int s = 0; s < sym_n; s++) begin
        read_hex(fd, val);
        leaf_freq[t][s] = val[freq_w-1:0];
      end
      for (int k = 0; k < exp_count[t]; k++) begin
        read_hex(fd, val);
        exp_left[t][k] = val[id_w-1:0];
        read_hex(fd, val);
        exp_right[t][k] = val[id_w-1:0];
        read_hex(fd, val);
        exp_sum[t][k] = val[freq_w-1:0];
      end
    end
    $fclose(fd);
    cycle_limit = n_builds * build_cycles;
  endtask

  // Start write, then status must show a fresh busy build
  task automatic start_build(input int t);
    logic [dat_w-1:0] q;
    bus_write(ctrl_adr, 32'd1);
    bus_read(stat_adr, q);
    check_stat(q[11:8], q[1], q[0], '0, 1'b0, 1'b1,
               $sformatf("test %0h status after start", test_id[t]));
  endtask

  // Frequency writes that the busy build must drop
  task automatic write_while_busy(input int t);
    logic [dat_w-1:0] q;
    logic [dat_w-1:0] junk;
    for (int s = 0; s < sym_n; s++) begin
      junk = $random(seed);
      bus_write(freq_base + adr_w'(s), junk & 32'h00ff_ffff);
    end
    bus_read(stat_adr, q);
    if (!q[0]) fail_run($sformatf("test %0h build ended before its busy writes", test_id[t]));
  endtask

  task automatic finish_build(input int t);
    logic [dat_w-1:0] q;
    string            tag;
    tag = $sformatf("test %0h", test_id[t]);
    q   = '0;
    while (!q[1]) bus_read(stat_adr, q);             // Poll for done
    check_stat(q[11:8], q[1], q[0], cnt_w'(exp_count[t]), 1'b1, 1'b0, {tag, " status at done"});
    for (int k = 0; k < exp_count[t]; k++) begin
      bus_read(node_base + adr_w'(2 * k), q);        // Left in 24:16, right in 8:0
      check_ids(q[24:16], q[8:0], exp_left[t][k], exp_right[t][k],
                $sformatf("%s node %0d", tag, k));
      bus_read(node_base + adr_w'(2 * k + 1), q);
      check_freq(q[freq_w-1:0], exp_sum[t][k], $sformatf("%s node %0d", tag, k));
    end
  endtask

  task automatic run_test(input int t);
    for (int s = 0; s < sym_n; s++) begin
      bus_write(freq_base + adr_w'(s), dat_w'(leaf_freq[t][s]));
    end
    start_build(t);
    if (test_mode[t] == 1) begin
      write_while_busy(t);
      finish_build(t);
      start_build(t);                                // Rerun on the untouched leaf table
    end
    finish_build(t);
  endtask

  initial begin
    logic [dat_w-1:0] q;
    rst_n = 1'b1;                                    // Reset is active high
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    wdata = '0;
    seed  = 32'h5cfc;
    load_tests();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b0;
    @(posedge clk);
    #1;
    bus_read(stat_adr, q);
    check_stat(q[11:8], q[1], q[0], '0, 1'b0, 1'b0, "status after reset");
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("test passed");
    $finish;
  end

endmodule

// File: test/huff_input.txt
# first line test count; per test: id mode node_count, 16 leaf frequencies, then per node
# left id, right id, sum; all hex; mode 1 writes frequencies while busy and reruns the build
5
1 0 f
14 3 f 7 1 1e c 5 9 2 19 b 28 6 12 4
004 009 000003
001 100 000006
00f 007 000009
00d 101 00000c
003 008 000010
102 00b 000014
006 103 000018
002 104 00001f
00e 000 000026
105 106 00002c
00a 005 000037
107 108 000045
00c 109 000054
10a 10b 00007c
10c 10d 0000d0
2 0 5
0 0 5 5 0 0 0 5 0 5 0 0 5 0 5 0
002 003 00000a
007 009 00000a
00c 00e 00000a
100 101 000014
102 103 00001e
3 0 1
0 0 0 0 0 0 0 0 0 0 0 2a 0 0 0 0
00b 180 00002a
4 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 1 3
0 800000 0 0 400000 0 400000 0 0 0 0 0 0 800000 0 0
004 006 800000
001 00d 000000
101 100 800000

// File: src.f
+incdir+test
verilog/huff_pkg.sv
verilog/huff_wb_regs.sv
verilog/huff_node_store.sv
verilog/huff_min_scan.sv
verilog/huff_tree_build.sv
verilog/huff_top.sv
test/huff_tb.sv

// File: Makefile
SIM := obj_dir/Vhuff_tb

run: $(SIM)
	./$(SIM)

$(SIM): src.f $(wildcard verilog/*.sv) test/huff_tb.sv test/huff_tb_tasks.svh
	verilator --binary --timing -j 0 --top-module huff_tb --Mdir obj_dir -f src.f -o Vhuff_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
